// ==== logic/hazard_macros.svh ====
`ifndef HAZARD_MACROS_SVH
`define HAZARD_MACROS_SVH

// architectural register file size
`define HZ_NUM_REGS 32

// cycles from accepting a writer until its result can be read,
// also the width of each age vector
`define HZ_WB_DEPTH 3

// younger instructions squashed by a taken branch
`define HZ_KILL_CYCLES 2

`endif

// ==== logic/hazard_pkg.sv ====
`default_nettype none

package hazard_pkg;

	typedef logic [4:0] reg_idx_t; // x0..x31
	typedef logic [6:0] opcode_t;  // instr[6:0]

	// grouped by which registers an instruction reads and writes
	typedef enum logic [2:0]
	{
		none       = 3'd0, // bubble or unknown op
		rd_only    = 3'd1, // lui, auipc, jal
		rs1_rs2_rd = 3'd2, // reg-reg alu
		rs1_rs2    = 3'd3, // branches, stores
		rs1_rd     = 3'd4  // jalr, imm alu, loads
	} hz_class_e;

	// rv32i major opcodes
	localparam opcode_t op_lui    = 7'b0110111;
	localparam opcode_t op_auipc  = 7'b0010111;
	localparam opcode_t op_jal    = 7'b1101111;
	localparam opcode_t op_jalr   = 7'b1100111;
	localparam opcode_t op_branch = 7'b1100011;
	localparam opcode_t op_load   = 7'b0000011;
	localparam opcode_t op_store  = 7'b0100011;
	localparam opcode_t op_imm    = 7'b0010011;
	localparam opcode_t op_reg    = 7'b0110011;

endpackage

`default_nettype wire

// ==== logic/opcode_classifier.sv ====
`timescale 1ns/100ps
`default_nettype none

module opcode_classifier
(
	input  wire hazard_pkg::opcode_t op_code,
	output logic                     use_rs1,
	output logic                     use_rs2,
	output logic                     writes_rd
);

	hazard_pkg::hz_class_e cls;

	always_comb
	begin
		unique case (op_code)
			hazard_pkg::op_lui,
			hazard_pkg::op_auipc,
			hazard_pkg::op_jal:
				cls = hazard_pkg::rd_only;
			hazard_pkg::op_reg:
				cls = hazard_pkg::rs1_rs2_rd;
			hazard_pkg::op_branch,
			hazard_pkg::op_store:
				cls = hazard_pkg::rs1_rs2;
			hazard_pkg::op_jalr,
			hazard_pkg::op_imm,
			hazard_pkg::op_load:
				cls = hazard_pkg::rs1_rd;
			default:
				cls = hazard_pkg::none; // fence, system, bubbles
		endcase
	end

	always_comb
	begin
		use_rs1   = 1'b0;
		use_rs2   = 1'b0;
		writes_rd = 1'b0;
		unique case (cls)
			hazard_pkg::rd_only:
				writes_rd = 1'b1;
			hazard_pkg::rs1_rs2_rd:
			begin
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				writes_rd = 1'b1;
			end
			hazard_pkg::rs1_rs2:
			begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1; // no rd, never marks
			end
			hazard_pkg::rs1_rd:
			begin
				use_rs1   = 1'b1;
				writes_rd = 1'b1; // rs2 field is imm here
			end
			default:
			begin
				use_rs1   = 1'b0;
				use_rs2   = 1'b0;
				writes_rd = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/reg_scoreboard.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "hazard_macros.svh"

module reg_scoreboard
(
	input  wire logic                 clk,
	input  wire logic                 nrst,
	input  wire hazard_pkg::reg_idx_t rs1,
	input  wire hazard_pkg::reg_idx_t rs2,
	input  wire hazard_pkg::reg_idx_t rd,
	input  wire logic                 use_rs1,
	input  wire logic                 use_rs2,
	input  wire logic                 writes_rd,
	input  wire logic                 kill,
	output logic                      stall,
	output logic [1:0]                stall_cycles
);

	// a set bit k means the result is still k+1 cycles or less from readable
	logic [`HZ_WB_DEPTH-1:0] age [`HZ_NUM_REGS];

	logic                    rs1_pend;
	logic                    rs2_pend;
	logic [`HZ_WB_DEPTH-1:0] src_age;
	logic                    accept;

	assign rs1_pend = use_rs1 && (rs1 != '0) && (|age[rs1]);
	assign rs2_pend = use_rs2 && (rs2 != '0) && (|age[rs2]);

	assign stall = (rs1_pend || rs2_pend) && !kill; // kill wins

	// merged age of the sources actually read
	always_comb
	begin
		src_age = '0;
		if (stall)
		begin
			if (rs1_pend)
				src_age = src_age | age[rs1];
			if (rs2_pend)
				src_age = src_age | age[rs2];
		end
	end

	always_comb
	begin
		stall_cycles = '0;
		for (int i = 0; i < `HZ_WB_DEPTH; i++)
		begin
			if (src_age[i])
				stall_cycles = 2'(i + 1); // highest set bit wins
		end
	end

	// killed or stalled instructions leave no mark
	assign accept = writes_rd && (rd != '0) && !stall && !kill;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < `HZ_NUM_REGS; i++)
				age[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < `HZ_NUM_REGS; i++)
			begin
				if (accept && (rd == hazard_pkg::reg_idx_t'(i)))
					age[i] <= '1; // rewrite beats shift
				else
					age[i] <= age[i] >> 1;
			end
		end
	end

	a_x0_never_pending: assert property (
		@(posedge clk) disable iff (!nrst)
		age[0] == '0
	)
		else $error("x0 marked as pending");

	a_stall_kill_exclusive: assert property (
		@(posedge clk) disable iff (!nrst)
		!(stall && kill)
	)
		else $error("stall raised during kill");

	a_count_matches_stall: assert property (
		@(posedge clk) disable iff (!nrst)
		(stall_cycles != '0) == stall
	)
		else $error("stall_cycles disagrees with stall");

	// a writer seen by a direct reader holds it off for the full depth
	a_full_wait: assert property (
		@(posedge clk) disable iff (!nrst)
		accept ##1 (use_rs1 && rs1 == $past(rd) && !kill) |-> stall_cycles == 2'(`HZ_WB_DEPTH)
	)
		else $error("short stall after a fresh writer");

endmodule

`default_nettype wire

// ==== logic/flush_control.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "hazard_macros.svh"

module flush_control
(
	input  wire logic clk,
	input  wire logic nrst,
	input  wire logic btaken,
	input  wire logic discard,
	output logic      kill
);

	// cycles of kill after the one btaken arrives in
	localparam int HOLD_W = `HZ_KILL_CYCLES - 1;

	logic [HOLD_W-1:0] hold;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			hold <= '0;
		end
		else
		begin
			hold <= (hold << 1) | HOLD_W'(btaken); // a new branch restarts the window
		end
	end

	// upstream already dropped the wrong-path op when discard is up
	assign kill = (btaken || (|hold)) && !discard;

	a_kill_bounded: assert property (
		@(posedge clk) disable iff (!nrst)
		(!btaken) [*`HZ_KILL_CYCLES] |-> !kill
	)
		else $error("kill outlived its branch");

endmodule

`default_nettype wire

// ==== logic/hazard_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module hazard_unit
(
	input  wire logic                 clk,
	input  wire logic                 nrst,
	input  wire hazard_pkg::opcode_t  op_code,
	input  wire hazard_pkg::reg_idx_t rs1,
	input  wire hazard_pkg::reg_idx_t rs2,
	input  wire hazard_pkg::reg_idx_t rd,
	input  wire logic                 btaken,
	input  wire logic                 discard,
	output logic                      stall,
	output logic                      kill,
	output logic [1:0]                stall_cycles
);

	logic use_rs1;
	logic use_rs2;
	logic writes_rd;

	// decode stage operand usage
	opcode_classifier u_classifier
	(
		.op_code   (op_code),
		.use_rs1   (use_rs1),
		.use_rs2   (use_rs2),
		.writes_rd (writes_rd)
	);

	flush_control u_flush
	(
		.clk     (clk),
		.nrst    (nrst),
		.btaken  (btaken),
		.discard (discard),
		.kill    (kill)
	);

	reg_scoreboard u_scoreboard
	(
		.clk          (clk),
		.nrst         (nrst),
		.rs1          (rs1),
		.rs2          (rs2),
		.rd           (rd),
		.use_rs1      (use_rs1),
		.use_rs2      (use_rs2),
		.writes_rd    (writes_rd),
		.kill         (kill), // blocks marking and stall
		.stall        (stall),
		.stall_cycles (stall_cycles)
	);

endmodule

`default_nettype wire

// ==== dv/hazard_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "hazard_macros.svh"

module hazard_unit_tb;

	localparam int reset_cycles    = 8;
	localparam int directed_cycles = 192;
	localparam int random_cycles   = 800;
	localparam int timeout_cycles  = 2 * (reset_cycles + directed_cycles + random_cycles);

	// rv32i major opcodes
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;

	logic                 clk = 1'b0;
	logic                 nrst;
	hazard_pkg::opcode_t  op_code;
	hazard_pkg::reg_idx_t rs1;
	hazard_pkg::reg_idx_t rs2;
	hazard_pkg::reg_idx_t rd;
	logic                 btaken;
	logic                 discard;
	wire logic            stall;
	wire logic            kill;
	wire logic [1:0]      stall_cycles;

	int errors = 0;
	int cycle_count = 0;

	// reference model state
	int         pend_left [`HZ_NUM_REGS]; // cycles until readable
	int         kill_left;
	int         left1;
	int         left2;
	logic       m_rd_only;
	logic       m_use1;
	logic       m_use2;
	logic       m_wr;
	logic       m_kill;
	logic       m_stall;
	logic       m_accept;
	logic [1:0] m_cycles;
	logic       stalled_q; // stall seen at the last edge

	hazard_unit uut
	(
		.clk          (clk),
		.nrst         (nrst),
		.op_code      (op_code),
		.rs1          (rs1),
		.rs2          (rs2),
		.rd           (rd),
		.btaken       (btaken),
		.discard      (discard),
		.stall        (stall),
		.kill         (kill),
		.stall_cycles (stall_cycles)
	);

	always #10 clk = ~clk;

	// {rd_only, reads rs1, reads rs2, writes rd}
	function automatic logic [3:0] classify(input logic [6:0] op);
		case (op)
			op_lui, op_auipc, op_jal:    return 4'b1001;
			op_reg:                      return 4'b0111;
			op_branch, op_store:         return 4'b0110;
			op_jalr, op_imm, op_load:    return 4'b0101;
			default:                     return 4'b0000;
		endcase
	endfunction

	function automatic logic [6:0] pick_opcode(input int sel, input logic [6:0] raw);
		case (sel)
			0:       return op_lui;
			1:       return op_auipc;
			2:       return op_jal;
			3:       return op_jalr;
			4:       return op_branch;
			5:       return op_load;
			6:       return op_store;
			7:       return op_imm;
			8:       return op_reg;
			default: return raw; // mostly unknown ops
		endcase
	endfunction

	always_comb
	begin
		{m_rd_only, m_use1, m_use2, m_wr} = classify(op_code);
		m_kill = (btaken || (kill_left > 0)) && !discard;
		left1 = (m_use1 && rs1 != 5'd0) ? pend_left[rs1] : 0;
		left2 = (m_use2 && rs2 != 5'd0) ? pend_left[rs2] : 0;
		m_stall = ((left1 > 0) || (left2 > 0)) && !m_kill;
		if (!m_stall)
			m_cycles = 2'd0;
		else if (left1 > left2)
			m_cycles = 2'(left1);
		else
			m_cycles = 2'(left2);
		m_accept = m_wr && (rd != 5'd0) && !m_stall && !m_kill;
	end

	always @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			kill_left <= 0;
			stalled_q <= 1'b0;
			for (int i = 0; i < `HZ_NUM_REGS; i++)
				pend_left[i] <= 0;
		end
		else
		begin
			stalled_q <= m_stall;
			if (btaken)
				kill_left <= `HZ_KILL_CYCLES - 1; // restarts on a second branch
			else if (kill_left > 0)
				kill_left <= kill_left - 1;
			for (int i = 0; i < `HZ_NUM_REGS; i++)
			begin
				if (m_accept && rd == 5'(i))
					pend_left[i] <= `HZ_WB_DEPTH;
				else if (pend_left[i] > 0)
					pend_left[i] <= pend_left[i] - 1;
			end
		end
	end

	a_reset_quiet: assert property (
		@(posedge clk) !nrst |-> (!stall && !kill && stall_cycles == 2'd0)
	)
		else
		begin
			errors++;
			$display("Mismatch at %0t: outputs active during reset", $time);
		end

	a_stall_model: assert property (@(posedge clk) disable iff (!nrst) stall == m_stall)
		else
		begin
			errors++;
			$display("Mismatch at %0t: stall %b, expected %b", $time, stall, m_stall);
		end

	a_kill_model: assert property (@(posedge clk) disable iff (!nrst) kill == m_kill)
		else
		begin
			errors++;
			$display("Mismatch at %0t: kill %b, expected %b", $time, kill, m_kill);
		end

	a_cycles_model: assert property (
		@(posedge clk) disable iff (!nrst) stall_cycles == m_cycles
	)
		else
		begin
			errors++;
			$display("Mismatch at %0t: stall_cycles %0d, expected %0d", $time,
				stall_cycles, m_cycles);
		end

	a_kill_over_stall: assert property (@(posedge clk) disable iff (!nrst) kill |-> !stall)
		else
		begin
			errors++;
			$display("Mismatch at %0t: stall high while kill is high", $time);
		end

	a_rd_only_free: assert property (@(posedge clk) disable iff (!nrst) m_rd_only |-> !stall)
		else
		begin
			errors++;
			$display("Mismatch at %0t: rd-only instruction stalled", $time);
		end

	task automatic report_and_finish(input logic timed_out);
		$display("errors: %0d", errors);
		if (errors == 0 && !timed_out)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	endtask

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= timeout_cycles)
		begin
			$display("timeout: run did not finish within %0d cycles", timeout_cycles);
			report_and_finish(1'b1);
		end
	end

	task automatic present(input logic [6:0] op, input logic [4:0] s1, input logic [4:0] s2,
		input logic [4:0] d, input logic bt, input logic dis);
		@(negedge clk);
		op_code = op;
		rs1     = s1;
		rs2     = s2;
		rd      = d;
		btaken  = bt;
		discard = dis;
	endtask

	task automatic bubble(input int n);
		repeat (n) present(7'h00, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0);
	endtask

	// reader stays on the inputs until stall drops
	task automatic wait_release;
		int n;
		n = 0;
		@(negedge clk);
		while (stall && n < 8)
		begin
			@(negedge clk);
			n++;
		end
		if (stall)
		begin
			errors++;
			$display("stall did not release after %0d cycles", n);
		end
	endtask

	initial
	begin
		void'($urandom(38));
		nrst    = 1'b0;
		op_code = 7'h00;
		rs1     = 5'd0;
		rs2     = 5'd0;
		rd      = 5'd0;
		btaken  = 1'b0;
		discard = 1'b0;
		repeat (reset_cycles) @(negedge clk);
		nrst = 1'b1;
		bubble(2);

		// read after write, direct and one cycle apart
		present(op_reg, 5'd1, 5'd2, 5'd5, 1'b0, 1'b0);
		present(op_reg, 5'd5, 5'd0, 5'd6, 1'b0, 1'b0);
		wait_release();
		bubble(4);
		present(op_load, 5'd3, 5'd0, 5'd7, 1'b0, 1'b0);
		present(op_imm, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0);
		present(op_reg, 5'd0, 5'd7, 5'd8, 1'b0, 1'b0);
		wait_release();
		bubble(4);

		// rs2 unused, x0 and rd-only
		present(op_imm, 5'd1, 5'd0, 5'd9, 1'b0, 1'b0);
		present(op_imm, 5'd1, 5'd9, 5'd0, 1'b0, 1'b0); // rs2 field is imm
		present(op_imm, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0);
		present(op_reg, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0);
		bubble(4);
		present(op_jal, 5'd0, 5'd0, 5'd10, 1'b0, 1'b0);
		present(op_lui, 5'd10, 5'd10, 5'd10, 1'b0, 1'b0);
		present(op_auipc, 5'd10, 5'd10, 5'd11, 1'b0, 1'b0);
		bubble(4);

		// branch kill and discard
		present(7'h00, 5'd0, 5'd0, 5'd0, 1'b1, 1'b0);
		bubble(3);
		present(7'h00, 5'd0, 5'd0, 5'd0, 1'b1, 1'b0);
		present(7'h00, 5'd0, 5'd0, 5'd0, 1'b0, 1'b1);
		present(7'h00, 5'd0, 5'd0, 5'd0, 1'b1, 1'b1);
		bubble(3);

		// writer squashed by kill leaves no mark
		present(op_reg, 5'd0, 5'd0, 5'd12, 1'b1, 1'b0);
		present(op_reg, 5'd12, 5'd0, 5'd0, 1'b0, 1'b0);
		present(op_reg, 5'd12, 5'd12, 5'd0, 1'b0, 1'b0);
		bubble(4);

		// kill hides a pending source
		present(op_imm, 5'd0, 5'd0, 5'd13, 1'b0, 1'b0);
		present(op_branch, 5'd13, 5'd0, 5'd0, 1'b1, 1'b0);
		present(op_branch, 5'd13, 5'd0, 5'd0, 1'b0, 1'b0);
		present(op_branch, 5'd13, 5'd0, 5'd0, 1'b0, 1'b0);
		wait_release();
		bubble(4);

		// random stream, instruction held while stalled
		for (int c = 0; c < random_cycles; c++)
		begin
			@(negedge clk);
			if (!stalled_q)
			begin
				op_code = pick_opcode(int'($urandom_range(11, 0)), 7'($urandom()));
				rs1     = 5'($urandom_range(7, 0));
				rs2     = 5'($urandom_range(7, 0));
				rd      = 5'($urandom_range(7, 0));
			end
			btaken  = ($urandom_range(15, 0) == 0);
			discard = ($urandom_range(7, 0) == 0);
		end
		bubble(4);
		report_and_finish(1'b0);
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+logic
logic/hazard_pkg.sv
logic/opcode_classifier.sv
logic/reg_scoreboard.sv
logic/flush_control.sv
logic/hazard_unit.sv
dv/hazard_unit_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = hazard_unit_tb
FILELIST = src.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
